// ==== hw/sb_config.svh ====
`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// --------------------------------------------------
// scoreboard sizing
// --------------------------------------------------

// ring depth, must stay a power of two so the
// count msb doubles as the full flag
`define SB_ENTRIES 8

// transaction id is the ring index
`define TRANS_ID_BITS 3

// result buses coming back from the functional units
`define NR_WB_PORTS 2

// --------------------------------------------------
// architectural widths
// --------------------------------------------------

`define XLEN 32
`define REG_ADDR_BITS 5
`define NR_REGS 32

`endif

// ==== hw/sb_pkg.sv ====
`include "sb_config.svh"

package sb_pkg;

  // --------------------------------------------------
  // widths with a meaning
  // --------------------------------------------------
  typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`XLEN-1:0]          xlen_t;
  // exception cause code as reported by the units
  typedef logic [5:0]                cause_t;

  // target functional unit of an instruction
  // FU_NONE needs no unit and completes by itself
  typedef enum logic [2:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE,
    FU_ALU,
    FU_CTRL_FLOW,
    FU_MULT,
    FU_CSR
  } fu_t;

  // one instruction as tracked between issue and commit
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      valid;
    logic      ex_valid;
    cause_t    ex_cause;
    trans_id_t trans_id;
  } sb_entry_t;

  // ring cell, issued marks an occupied slot
  typedef struct packed {
    logic      issued;
    sb_entry_t sbe;
  } sb_slot_t;

  // one write-back port from a functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
    cause_t    ex_cause;
  } wb_t;

endpackage

// ==== hw/sb_queue.sv ====
`include "sb_config.svh"

module sb_queue (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic                                 flush_unissued_i,
  // decoder side
  input  sb_pkg::sb_entry_t                    decoded_instr_i,
  input  logic                                 decoded_valid_i,
  output logic                                 decoded_ack_o,
  // issue stage side
  output sb_pkg::sb_entry_t                    issue_instr_o,
  output logic                                 issue_valid_o,
  input  logic                                 issue_ack_i,
  // results from the functional units
  input  sb_pkg::wb_t [`NR_WB_PORTS-1:0]       wb_i,
  // commit stage side
  output sb_pkg::sb_entry_t                    commit_instr_o,
  input  logic                                 commit_ack_i,
  output logic                                 sb_full_o,
  // whole ring state for clobber and forwarding
  output sb_pkg::sb_slot_t [`SB_ENTRIES-1:0]   slots_o
);

  import sb_pkg::*;

  // ring storage
  sb_slot_t [`SB_ENTRIES-1:0] slot_q, slot_d;

  // pointers into the ring
  trans_id_t issue_ptr_q, issue_ptr_d;
  trans_id_t commit_ptr_q, commit_ptr_d;

  // one bit wider than the index, msb set means all entries held
  logic [`TRANS_ID_BITS:0] cnt_q, cnt_d;

  logic full;
  logic issue_fire;
  logic commit_fire;

  assign full      = cnt_q[`TRANS_ID_BITS];
  assign sb_full_o = full;

  // --------------------------------------------------
  // issue handshake
  // --------------------------------------------------
  // decoded entry goes out tagged with the slot it will occupy
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
  end

  // no acceptance at all while the ring is full
  assign issue_valid_o = decoded_valid_i & ~full;
  assign decoded_ack_o = issue_ack_i & ~full;

  // an instruction offered during flush_unissued is dropped
  assign issue_fire  = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;
  assign commit_fire = commit_ack_i;

  // commit port always shows the oldest slot
  always_comb begin
    commit_instr_o          = slot_q[commit_ptr_q].sbe;
    commit_instr_o.trans_id = commit_ptr_q;
  end

  assign slots_o = slot_q;

  // --------------------------------------------------
  // next ring state
  // --------------------------------------------------
  // later sections override earlier ones
  always_comb begin
    slot_d = slot_q;

    // new instruction at the issue pointer
    if (issue_fire) begin
      slot_d[issue_ptr_q].issued = 1'b1;
      slot_d[issue_ptr_q].sbe    = issue_instr_o;
    end

    // no unit to wait for, completes on the next edge
    for (int unsigned i = 0; i < `SB_ENTRIES; i++) begin
      if (slot_q[i].issued && slot_q[i].sbe.fu == FU_NONE) begin
        slot_d[i].sbe.valid = 1'b1;
      end
    end

    // write-back, stale results for free slots are dropped
    for (int unsigned p = 0; p < `NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && slot_q[wb_i[p].trans_id].issued) begin
        slot_d[wb_i[p].trans_id].sbe.valid  = 1'b1;
        slot_d[wb_i[p].trans_id].sbe.result = wb_i[p].data;
        // keep the exception with the entry until commit
        if (wb_i[p].ex_valid) begin
          slot_d[wb_i[p].trans_id].sbe.ex_valid = 1'b1;
          slot_d[wb_i[p].trans_id].sbe.ex_cause = wb_i[p].ex_cause;
        end
      end
    end

    // retire the oldest slot
    if (commit_fire) begin
      slot_d[commit_ptr_q].issued    = 1'b0;
      slot_d[commit_ptr_q].sbe.valid = 1'b0;
    end

    // flush wins over everything above
    if (flush_i) begin
      for (int unsigned i = 0; i < `SB_ENTRIES; i++) begin
        slot_d[i].issued       = 1'b0;
        slot_d[i].sbe.valid    = 1'b0;
        slot_d[i].sbe.ex_valid = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_comb begin
    issue_ptr_d  = issue_ptr_q;
    commit_ptr_d = commit_ptr_q;
    // issue and commit together leave the count as is
    cnt_d = cnt_q + {{`TRANS_ID_BITS{1'b0}}, issue_fire}
                  - {{`TRANS_ID_BITS{1'b0}}, commit_fire};

    if (issue_fire) begin
      issue_ptr_d = issue_ptr_q + trans_id_t'(1);
    end
    if (commit_fire) begin
      commit_ptr_d = commit_ptr_q + trans_id_t'(1);
    end

    if (flush_i) begin
      issue_ptr_d  = '0;
      commit_ptr_d = '0;
      cnt_d        = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      slot_q       <= slot_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

endmodule

// ==== hw/sb_clobber.sv ====
`include "sb_config.svh"

module sb_clobber (
  input  sb_pkg::sb_slot_t [`SB_ENTRIES-1:0] slots_i,
  output sb_pkg::fu_t      [`NR_REGS-1:0]    rd_clobber_o
);

  import sb_pkg::*;

  // --------------------------------------------------
  // pending writer per register
  // --------------------------------------------------
  // one writer per rd is expected in flight, on a tie the
  // lowest ring index is reported
  always_comb begin
    for (int unsigned r = 0; r < `NR_REGS; r++) begin
      // default when nothing in flight targets r
      rd_clobber_o[r] = FU_NONE;

      // walk downwards so the lowest match lands last
      for (int i = `SB_ENTRIES - 1; i >= 0; i--) begin
        if (slots_i[i].issued && slots_i[i].sbe.rd == reg_addr_t'(r)) begin
          rd_clobber_o[r] = slots_i[i].sbe.fu;
        end
      end
    end

    // x0 is hardwired, never waits on a unit
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

// ==== hw/sb_forward.sv ====
`include "sb_config.svh"

module sb_forward (
  input  sb_pkg::sb_slot_t [`SB_ENTRIES-1:0]  slots_i,
  input  sb_pkg::wb_t      [`NR_WB_PORTS-1:0] wb_i,
  // operand addresses from issue
  input  sb_pkg::reg_addr_t                   rs1_i,
  input  sb_pkg::reg_addr_t                   rs2_i,
  // forwarded values
  output sb_pkg::xlen_t                       rs1_o,
  output sb_pkg::xlen_t                       rs2_o,
  output logic                                rs1_valid_o,
  output logic                                rs2_valid_o
);

  import sb_pkg::*;

  // --------------------------------------------------
  // operand selector
  // --------------------------------------------------
  // fixed priority: wb ports first, then ring entries,
  // lower index wins inside each group
  function automatic void fwd_pick(
    input  reg_addr_t                   rs,
    input  sb_slot_t [`SB_ENTRIES-1:0]  slots,
    input  wb_t      [`NR_WB_PORTS-1:0] wb,
    output xlen_t                       data,
    output logic                        hit
  );
    hit  = 1'b0;
    data = '0;

    // completed entries still waiting for commit
    for (int i = `SB_ENTRIES - 1; i >= 0; i--) begin
      if (slots[i].issued && slots[i].sbe.valid && slots[i].sbe.rd == rs) begin
        hit  = 1'b1;
        data = slots[i].sbe.result;
      end
    end

    // results on the bus this cycle override stored ones
    // a faulting result is never forwarded
    for (int p = `NR_WB_PORTS - 1; p >= 0; p--) begin
      if (wb[p].valid && !wb[p].ex_valid && slots[wb[p].trans_id].sbe.rd == rs) begin
        hit  = 1'b1;
        data = wb[p].data;
      end
    end

    // x0 reads come from the register file
    if (rs == '0) begin
      hit = 1'b0;
    end
  endfunction

  // same selector for both operands
  always_comb begin
    fwd_pick(rs1_i, slots_i, wb_i, rs1_o, rs1_valid_o);
    fwd_pick(rs2_i, slots_i, wb_i, rs2_o, rs2_valid_o);
  end

endmodule

// ==== hw/scoreboard.sv ====
`include "sb_config.svh"

module scoreboard (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                flush_unissued_i,
  output logic                                sb_full_o,
  // decoder
  input  sb_pkg::sb_entry_t                   decoded_instr_i,
  input  logic                                decoded_valid_i,
  output logic                                decoded_ack_o,
  // issue stage
  output sb_pkg::sb_entry_t                   issue_instr_o,
  output logic                                issue_valid_o,
  input  logic                                issue_ack_i,
  // functional unit results
  input  sb_pkg::wb_t      [`NR_WB_PORTS-1:0] wb_i,
  // commit stage
  output sb_pkg::sb_entry_t                   commit_instr_o,
  input  logic                                commit_ack_i,
  // destination clobber table
  output sb_pkg::fu_t      [`NR_REGS-1:0]     rd_clobber_o,
  // operand read
  input  sb_pkg::reg_addr_t                   rs1_i,
  input  sb_pkg::reg_addr_t                   rs2_i,
  output sb_pkg::xlen_t                       rs1_o,
  output sb_pkg::xlen_t                       rs2_o,
  output logic                                rs1_valid_o,
  output logic                                rs2_valid_o
);

  import sb_pkg::*;

  // ring state shared by the lookup blocks
  sb_slot_t [`SB_ENTRIES-1:0] slots;

  // --------------------------------------------------
  // ring with issue, write-back and commit
  // --------------------------------------------------
  sb_queue i_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .flush_unissued_i(flush_unissued_i),
    .decoded_instr_i (decoded_instr_i),
    .decoded_valid_i (decoded_valid_i),
    .decoded_ack_o   (decoded_ack_o),
    .issue_instr_o   (issue_instr_o),
    .issue_valid_o   (issue_valid_o),
    .issue_ack_i     (issue_ack_i),
    .wb_i            (wb_i),
    .commit_instr_o  (commit_instr_o),
    .commit_ack_i    (commit_ack_i),
    .sb_full_o       (sb_full_o),
    .slots_o         (slots)
  );

  // pending writer unit per register
  sb_clobber i_clobber (
    .slots_i     (slots),
    .rd_clobber_o(rd_clobber_o)
  );

  // operand bypass from buses and completed entries
  sb_forward i_forward (
    .slots_i    (slots),
    .wb_i       (wb_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .rs1_o      (rs1_o),
    .rs2_o      (rs2_o),
    .rs1_valid_o(rs1_valid_o),
    .rs2_valid_o(rs2_valid_o)
  );

endmodule

// ==== bench/sb_checker.sv ====
`include "sb_config.svh"

module sb_checker (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic                                issue_valid_o,
  input logic                                issue_ack_i,
  input logic                                commit_ack_i,
  input sb_pkg::sb_entry_t                   commit_instr_o,
  input sb_pkg::wb_t      [`NR_WB_PORTS-1:0] wb_i,
  input sb_pkg::fu_t      [`NR_REGS-1:0]     rd_clobber_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import sb_pkg::*;

  // number of assertion failures so far
  int fail_count = 0;

  // --------------------------------------------------
  // protocol and table properties
  // --------------------------------------------------

  // x0 is hardwired and never waits on a unit
  x0_clobber: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == FU_NONE)
    else begin
      $error("clobber entry of x0 is not FU_NONE");
      fail_count++;
    end

  // commit only retires a finished entry
  commit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_instr_o.valid)
    else begin
      $error("commit acknowledged while the oldest entry is not valid");
      fail_count++;
    end

  // issue stage acks only what was offered
  issue_offer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o)
    else begin
      $error("issue acknowledged without a valid issue offer");
      fail_count++;
    end

  // two result buses never complete the same entry
  wb_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_i[0].valid && wb_i[1].valid && wb_i[0].trans_id == wb_i[1].trans_id))
    else begin
      $error("both write-back ports carry the same transaction id");
      fail_count++;
    end

endmodule

bind scoreboard sb_checker i_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_valid_o (issue_valid_o),
  .issue_ack_i   (issue_ack_i),
  .commit_ack_i  (commit_ack_i),
  .commit_instr_o(commit_instr_o),
  .wb_i          (wb_i),
  .rd_clobber_o  (rd_clobber_o)
);

// ==== bench/tb_scoreboard.sv ====
`include "sb_config.svh"

module tb_scoreboard;
  timeunit 1ns;
  timeprecision 100ps;

  import sb_pkg::*;

  typedef enum logic [2:0] {
    OP_IDLE,
    OP_ISSUE,
    OP_FLUSH_ISSUE,
    OP_WB0,
    OP_WB1,
    OP_COMMIT,
    OP_FLUSH,
    OP_READ
  } op_t;

  // one table row, stimulus first, then expected outputs
  // commit rows hold the expected entry in fu, rd, tid, data and ex
  typedef struct packed {
    op_t       op;
    fu_t       fu;
    reg_addr_t rd;
    trans_id_t tid;
    xlen_t     data;
    cause_t    ex;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      full;
    logic      cvalid;
    logic      rs1_valid;
    xlen_t     rs1_data;
    logic      rs2_valid;
    xlen_t     rs2_data;
    reg_addr_t clob_rd;
    fu_t       clob_fu;
  } step_t;

  logic clk, rst_n, flush, flush_unissued, full;
  logic dec_valid, dec_ack, issue_valid, issue_ack, commit_ack;
  logic rs1_valid, rs2_valid;
  sb_entry_t dec_instr, issue_instr, commit_instr;
  wb_t [`NR_WB_PORTS-1:0] wb;
  fu_t [`NR_REGS-1:0] clobber;
  reg_addr_t rs1, rs2;
  xlen_t rs1_data, rs2_data;
  step_t steps[$];
  xlen_t dw[8];
  int seed = 24683;
  int errors = 0;

  scoreboard dut (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .flush_unissued_i(flush_unissued),
    .sb_full_o(full), .decoded_instr_i(dec_instr), .decoded_valid_i(dec_valid),
    .decoded_ack_o(dec_ack), .issue_instr_o(issue_instr), .issue_valid_o(issue_valid),
    .issue_ack_i(issue_ack), .wb_i(wb), .commit_instr_o(commit_instr),
    .commit_ack_i(commit_ack), .rd_clobber_o(clobber), .rs1_i(rs1), .rs2_i(rs2),
    .rs1_o(rs1_data), .rs2_o(rs2_data), .rs1_valid_o(rs1_valid), .rs2_valid_o(rs2_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
      $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // -1 selects zero data
  function automatic xlen_t word(input int idx);
    return (idx < 0) ? '0 : dw[idx];
  endfunction

  // f1 and f2 index the forwarded word, -1 means no forward expected
  task automatic add_step(input op_t op, input fu_t fu, input int rd, input int tid,
                          input int di, input int ex, input int rs1, input int f1,
                          input int rs2, input int f2, input bit full, input bit cv,
                          input int crd, input fu_t cfu);
    step_t s;
    s.op        = op;
    s.fu        = fu;
    s.rd        = reg_addr_t'(rd);
    s.tid       = trans_id_t'(tid);
    s.data      = word(di);
    s.ex        = cause_t'(ex);
    s.rs1       = reg_addr_t'(rs1);
    s.rs2       = reg_addr_t'(rs2);
    s.full      = full;
    s.cvalid    = cv;
    s.rs1_valid = (f1 >= 0);
    s.rs1_data  = word(f1);
    s.rs2_valid = (f2 >= 0);
    s.rs2_data  = word(f2);
    s.clob_rd   = reg_addr_t'(crd);
    s.clob_fu   = cfu;
    steps.push_back(s);
  endtask

  task automatic drive_idle();
    flush          = 1'b0;
    flush_unissued = 1'b0;
    dec_valid      = 1'b0;
    issue_ack      = 1'b0;
    commit_ack     = 1'b0;
    dec_instr      = '0;
    wb             = '0;
  endtask

  task automatic wait_commit_valid(output bit ok);
    int n;
    n = 0;
    while (!commit_instr.valid && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = commit_instr.valid;
    assert (ok) else begin
      $display("commit entry still not valid after 20 cycles at %0t ns", $time);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // one row: drive after the edge, check before the next
  // --------------------------------------------------
  task automatic apply_step(input step_t s);
    bit ok;
    int p;
    @(posedge clk);
    #1;
    drive_idle();
    ok = 1'b1;
    if (s.op == OP_COMMIT) wait_commit_valid(ok);
    case (s.op)
      OP_ISSUE, OP_FLUSH_ISSUE: begin
        dec_valid      = 1'b1;
        issue_ack      = 1'b1;
        dec_instr.fu   = s.fu;
        dec_instr.rd   = s.rd;
        flush_unissued = (s.op == OP_FLUSH_ISSUE);
      end
      OP_WB0, OP_WB1: begin
        p = (s.op == OP_WB1) ? 1 : 0;
        wb[p].valid    = 1'b1;
        wb[p].trans_id = s.tid;
        wb[p].data     = s.data;
        wb[p].ex_valid = (s.ex != 0);
        wb[p].ex_cause = s.ex;
      end
      OP_COMMIT: commit_ack = ok;
      OP_FLUSH:  flush = 1'b1;
      default: ;
    endcase
    rs1 = s.rs1;
    rs2 = s.rs2;
    #7;
    check_eq("sb_full_o", full, s.full);
    if (s.op == OP_ISSUE || s.op == OP_FLUSH_ISSUE) begin
      check_eq("issue_valid_o", issue_valid, !s.full);
      check_eq("decoded_ack_o", dec_ack, !s.full);
      check_eq("issue_instr_o.trans_id", issue_instr.trans_id, s.tid);
    end
    check_eq("commit_instr_o.valid", commit_instr.valid, s.cvalid);
    if (s.op == OP_COMMIT) begin
      check_eq("commit_instr_o.fu", commit_instr.fu, s.fu);
      check_eq("commit_instr_o.rd", commit_instr.rd, s.rd);
      check_eq("commit_instr_o.trans_id", commit_instr.trans_id, s.tid);
      check_eq("commit_instr_o.result", commit_instr.result, s.data);
      check_eq("commit_instr_o.ex_valid", commit_instr.ex_valid, s.ex != 0);
      if (s.ex != 0) check_eq("commit_instr_o.ex_cause", commit_instr.ex_cause, s.ex);
    end
    check_eq("rs1_valid_o", rs1_valid, s.rs1_valid);
    if (s.rs1_valid) check_eq("rs1_o", rs1_data, s.rs1_data);
    check_eq("rs2_valid_o", rs2_valid, s.rs2_valid);
    if (s.rs2_valid) check_eq("rs2_o", rs2_data, s.rs2_data);
    check_eq($sformatf("rd_clobber_o[%0d]", s.clob_rd), clobber[s.clob_rd], s.clob_fu);
    // issue stage backs off when nothing is offered
    if (s.full) issue_ack = 1'b0;
  endtask

  task automatic build_table();
    // in-order ids, write-back with forwarding, exception, auto-completion
    // the FU_NONE nop targets x0 so the x0 reads below see a completed writer
    add_step(OP_ISSUE, FU_ALU, 1, 0, -1, 0, 0, -1, 0, -1, 0, 0, 1, FU_NONE);
    add_step(OP_ISSUE, FU_LOAD, 2, 1, -1, 0, 0, -1, 0, -1, 0, 0, 1, FU_ALU);
    add_step(OP_ISSUE, FU_NONE, 0, 2, -1, 0, 0, -1, 0, -1, 0, 0, 2, FU_LOAD);
    add_step(OP_WB0, FU_NONE, 0, 0, 0, 0, 1, 0, 0, -1, 0, 0, 2, FU_LOAD);
    add_step(OP_WB1, FU_NONE, 0, 1, 1, 5, 2, -1, 1, 0, 0, 1, 1, FU_ALU);
    add_step(OP_COMMIT, FU_ALU, 1, 0, 0, 0, 1, 0, 0, -1, 0, 1, 1, FU_ALU);
    add_step(OP_COMMIT, FU_LOAD, 2, 1, 1, 5, 0, -1, 0, -1, 0, 1, 1, FU_NONE);
    add_step(OP_COMMIT, FU_NONE, 0, 2, -1, 0, 0, -1, 0, -1, 0, 1, 2, FU_NONE);
    // fill all eight slots, then back-pressure
    for (int k = 0; k < 8; k++) begin
      add_step(OP_ISSUE, FU_ALU, 8 + k, (3 + k) % 8, -1, 0, 0, -1, 0, -1, 0, 0, 8,
               (k == 0) ? FU_NONE : FU_ALU);
    end
    add_step(OP_ISSUE, FU_ALU, 16, 3, -1, 0, 0, -1, 0, -1, 1, 0, 15, FU_ALU);
    add_step(OP_WB0, FU_NONE, 0, 3, 2, 0, 8, 2, 9, -1, 1, 0, 8, FU_ALU);
    add_step(OP_COMMIT, FU_ALU, 8, 3, 2, 0, 0, -1, 0, -1, 1, 1, 8, FU_ALU);
    add_step(OP_READ, FU_NONE, 0, 0, -1, 0, 8, -1, 0, -1, 0, 0, 8, FU_NONE);
    // flush, then an issue dropped by flush_unissued
    add_step(OP_FLUSH, FU_NONE, 0, 0, -1, 0, 0, -1, 0, -1, 0, 0, 9, FU_ALU);
    add_step(OP_FLUSH_ISSUE, FU_ALU, 20, 0, -1, 0, 0, -1, 0, -1, 0, 0, 9, FU_NONE);
    add_step(OP_ISSUE, FU_CSR, 21, 0, -1, 0, 0, -1, 0, -1, 0, 0, 20, FU_NONE);
    add_step(OP_WB1, FU_NONE, 0, 0, 3, 0, 21, 3, 0, -1, 0, 0, 21, FU_CSR);
    add_step(OP_COMMIT, FU_CSR, 21, 0, 3, 0, 0, -1, 0, -1, 0, 1, 21, FU_CSR);
    add_step(OP_IDLE, FU_NONE, 0, 0, -1, 0, 0, -1, 0, -1, 0, 0, 21, FU_NONE);
  endtask

  initial begin
    rst_n = 1'b0;
    rs1   = '0;
    rs2   = '0;
    drive_idle();
    for (int i = 0; i < 8; i++) dw[i] = $random(seed);
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (steps[i]) apply_step(steps[i]);
    // let the last edges reach the bound checker
    repeat (2) @(posedge clk);
    errors += dut.i_checker.fail_count;
    $display("scoreboard checks finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hw
hw/sb_pkg.sv
hw/sb_queue.sv
hw/sb_clobber.sv
hw/sb_forward.sv
hw/scoreboard.sv
bench/sb_checker.sv
bench/tb_scoreboard.sv

// ==== run.sh ====
#!/bin/sh
# build the scoreboard testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scoreboard -f sources.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_scoreboard +verilator+error+limit+100)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
